/* bench/csr_file_tb.sv */
// Random CSR testbench with a cycle model; mepc, mtval and mscratch are compared only once loaded
`timescale 1ns/1ps

module csr_file_tb;

	localparam int max_cycles = 4000; // Run limit in clock cycles
	localparam int random_cycles = 3000;

	logic clk;
	logic resetn;
	csr_pkg::csr_addr_t csr_addr;
	csr_pkg::upd_kind_t csr_kind;
	csr_pkg::csr_word_t csr_wdata;
	logic csr_valid;
	csr_pkg::csr_word_t csr_rdata;
	logic trap_enter;
	logic trap_is_intr;
	logic [csr_pkg::cause_w-1:0] trap_cause;
	csr_pkg::csr_word_t trap_ret_addr;
	csr_pkg::csr_word_t trap_value;
	csr_pkg::csr_word_t trap_vec_addr;
	logic trap_ret;
	csr_pkg::csr_word_t mepc_ret_addr;
	logic sw_irq;
	logic tmr_irq;
	logic ext_irq;
	logic retire;
	logic in_dbg_mode;
	logic mstatus_mie;
	logic mie_msie;
	logic mie_mtie;
	logic mie_meie;

	// Reference model state
	logic exp_mie;
	logic exp_mpie;
	csr_pkg::csr_word_t exp_mtvec;
	csr_pkg::csr_word_t exp_mepc;
	csr_pkg::csr_word_t exp_mcause;
	csr_pkg::csr_word_t exp_mtval;
	csr_pkg::csr_word_t exp_mscratch;
	logic [2:0] exp_en; // Bit 0 msi, 1 mti, 2 mei
	logic [2:0] exp_pend;
	logic [63:0] exp_cycle;
	logic [63:0] exp_instret;
	logic known_mepc;
	logic known_mtval;
	logic known_mscratch;

	logic [31:0] rng_state;
	int cycle_count;
	int wait_count;
	csr_pkg::csr_addr_t reset_addrs[9];
	csr_pkg::csr_addr_t load_addrs[3];
	logic [31:0] r;

	csr_file UUT
	(
		.clk(clk), .resetn(resetn),
		.csr_addr(csr_addr), .csr_kind(csr_kind), .csr_wdata(csr_wdata),
		.csr_valid(csr_valid), .csr_rdata(csr_rdata),
		.trap_enter(trap_enter), .trap_is_intr(trap_is_intr), .trap_cause(trap_cause),
		.trap_ret_addr(trap_ret_addr), .trap_value(trap_value), .trap_vec_addr(trap_vec_addr),
		.trap_ret(trap_ret), .mepc_ret_addr(mepc_ret_addr),
		.sw_irq(sw_irq), .tmr_irq(tmr_irq), .ext_irq(ext_irq),
		.retire(retire), .in_dbg_mode(in_dbg_mode),
		.mstatus_mie(mstatus_mie), .mie_msie(mie_msie), .mie_mtie(mie_mtie), .mie_meie(mie_meie)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] value);
		rng_state = xorshift32(rng_state);
		value = rng_state;
	endtask

	task automatic stop_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped after the first error");
	endtask

	task automatic check_word(csr_pkg::csr_word_t got, csr_pkg::csr_word_t exp, string what);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_bit(logic got, logic exp, string what);
		if (got !== exp)
		begin
			$display("FAIL at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	function automatic logic hits(csr_pkg::csr_addr_t a);
		return csr_valid && (csr_addr == a);
	endfunction

	function automatic csr_pkg::csr_word_t status_word();
		csr_pkg::csr_word_t w;
		w = csr_pkg::mstatus_mpp_bits;
		w[csr_pkg::bit_mie] = exp_mie;
		w[csr_pkg::bit_mpie] = exp_mpie;
		return w;
	endfunction

	function automatic csr_pkg::csr_word_t irq_word(logic [2:0] b);
		csr_pkg::csr_word_t w;
		w = '0;
		w[csr_pkg::bit_msi] = b[0];
		w[csr_pkg::bit_mti] = b[1];
		w[csr_pkg::bit_mei] = b[2];
		return w;
	endfunction

	function automatic csr_pkg::csr_word_t model_read(csr_pkg::csr_addr_t a);
		csr_pkg::csr_word_t w;
		case (a)
			csr_pkg::addr_mstatus: w = status_word();
			csr_pkg::addr_misa: w = csr_pkg::misa_value;
			csr_pkg::addr_mie: w = irq_word(exp_en);
			csr_pkg::addr_mtvec: w = exp_mtvec;
			csr_pkg::addr_mscratch: w = exp_mscratch;
			csr_pkg::addr_mepc: w = exp_mepc;
			csr_pkg::addr_mcause: w = exp_mcause;
			csr_pkg::addr_mtval: w = exp_mtval;
			csr_pkg::addr_mip: w = irq_word(exp_pend);
			csr_pkg::addr_mcycle: w = exp_cycle[31:0];
			csr_pkg::addr_mcycleh: w = exp_cycle[63:32];
			csr_pkg::addr_minstret: w = exp_instret[31:0];
			csr_pkg::addr_minstreth: w = exp_instret[63:32];
			csr_pkg::addr_mvendorid: w = csr_pkg::mvendorid_value;
			csr_pkg::addr_marchid: w = csr_pkg::marchid_value;
			csr_pkg::addr_mimpid: w = csr_pkg::mimpid_value;
			csr_pkg::addr_mhartid: w = csr_pkg::mhartid_value;
			default: w = '0; // Unknown address
		endcase
		return w;
	endfunction

	function automatic logic value_known(csr_pkg::csr_addr_t a);
		if ((a == csr_pkg::addr_mepc) && !known_mepc)
			return 1'b0;
		if ((a == csr_pkg::addr_mtval) && !known_mtval)
			return 1'b0;
		return !((a == csr_pkg::addr_mscratch) && !known_mscratch);
	endfunction

	function automatic csr_pkg::csr_word_t expected_vector();
		csr_pkg::csr_word_t base;
		csr_pkg::csr_word_t cause_word;
		base = {exp_mtvec[csr_pkg::xlen-1:2], 2'b00};
		cause_word = {{(csr_pkg::xlen-csr_pkg::cause_w){1'b0}}, trap_cause};
		if ((exp_mtvec[1:0] == csr_pkg::mtvec_mode_vectored) && trap_is_intr)
			return base + cause_word * 32'd4;
		return base;
	endfunction

	// Next 64-bit count; a write to one word leaves the other word counting
	function automatic logic [63:0] counter_next(logic [63:0] cur, csr_pkg::csr_addr_t lo_a,
		csr_pkg::csr_addr_t hi_a, logic en);
		csr_pkg::csr_word_t lo;
		csr_pkg::csr_word_t hi;
		lo = cur[31:0];
		hi = cur[63:32];
		if (hits(lo_a))
			lo = csr_pkg::csr_update(cur[31:0], csr_kind, csr_wdata);
		else if (en)
			lo = lo + 32'd1;
		if (hits(hi_a))
			hi = csr_pkg::csr_update(cur[63:32], csr_kind, csr_wdata);
		else if (en && (cur[31:0] == 32'hFFFF_FFFF))
			hi = hi + 32'd1;
		return {hi, lo};
	endfunction

	task automatic update_model();
		csr_pkg::csr_word_t new_status;
		csr_pkg::csr_word_t new_mie;
		logic [63:0] cyc_next;
		logic [63:0] ins_next;
		new_status = csr_pkg::csr_update(status_word(), csr_kind, csr_wdata);
		new_mie = csr_pkg::csr_update(irq_word(exp_en), csr_kind, csr_wdata);
		cyc_next = counter_next(exp_cycle, csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh,
			!in_dbg_mode);
		ins_next = counter_next(exp_instret, csr_pkg::addr_minstret, csr_pkg::addr_minstreth,
			retire && !in_dbg_mode);
		if (!resetn)
		begin
			exp_mie = 1'b0;
			exp_mpie = 1'b1;
			exp_mtvec = {csr_pkg::rst_mtvec_base, 2'b00};
			exp_mcause = csr_pkg::rst_mcause;
			exp_en = 3'b000;
			exp_pend = 3'b000;
			exp_cycle = '0;
			exp_instret = '0;
			return;
		end
		if (trap_enter)
		begin
			exp_mpie = exp_mie; // Old MIE saved
			exp_mie = 1'b0;
			exp_mcause = {trap_is_intr, {(csr_pkg::xlen-1-csr_pkg::cause_w){1'b0}}, trap_cause};
			exp_mepc = trap_ret_addr;
			exp_mtval = trap_value;
			known_mepc = 1'b1;
			known_mtval = 1'b1;
		end
		else
		begin
			if (trap_ret)
			begin
				exp_mie = exp_mpie;
				exp_mpie = 1'b1;
			end
			else if (hits(csr_pkg::addr_mstatus))
			begin
				exp_mie = new_status[csr_pkg::bit_mie];
				exp_mpie = new_status[csr_pkg::bit_mpie];
			end
			if (hits(csr_pkg::addr_mcause))
				exp_mcause = csr_pkg::csr_update(exp_mcause, csr_kind, csr_wdata);
			if (hits(csr_pkg::addr_mepc))
			begin
				exp_mepc = csr_pkg::csr_update(exp_mepc, csr_kind, csr_wdata);
				known_mepc = known_mepc || (csr_kind == csr_pkg::upd_load);
			end
			if (hits(csr_pkg::addr_mtval))
			begin
				exp_mtval = csr_pkg::csr_update(exp_mtval, csr_kind, csr_wdata);
				known_mtval = known_mtval || (csr_kind == csr_pkg::upd_load);
			end
		end
		if (hits(csr_pkg::addr_mtvec))
			exp_mtvec = csr_pkg::csr_update(exp_mtvec, csr_kind, csr_wdata);
		if (hits(csr_pkg::addr_mscratch))
		begin
			exp_mscratch = csr_pkg::csr_update(exp_mscratch, csr_kind, csr_wdata);
			known_mscratch = known_mscratch || (csr_kind == csr_pkg::upd_load);
		end
		if (hits(csr_pkg::addr_mie))
			exp_en = {new_mie[csr_pkg::bit_mei], new_mie[csr_pkg::bit_mti],
				new_mie[csr_pkg::bit_msi]};
		exp_pend = {ext_irq, tmr_irq, sw_irq}; // mip lags by one edge
		exp_cycle = cyc_next;
		exp_instret = ins_next;
	endtask

	task automatic advance_edge();
		@(posedge clk);
		cycle_count = cycle_count + 1;
		if (cycle_count > max_cycles)
		begin
			$display("Timeout: the run went past %0d clock cycles", max_cycles);
			stop_run();
		end
		update_model(); // Sees the inputs of the cycle that just ended
	endtask

	task automatic check_outputs();
		@(negedge clk);
		if (value_known(csr_addr))
			check_word(csr_rdata, model_read(csr_addr), $sformatf("csr_rdata at %h", csr_addr));
		check_word(trap_vec_addr, expected_vector(), "trap_vec_addr");
		if (known_mepc)
			check_word(mepc_ret_addr, exp_mepc, "mepc_ret_addr");
		check_bit(mstatus_mie, exp_mie, "mstatus_mie");
		check_bit(mie_msie, exp_en[0], "mie_msie");
		check_bit(mie_mtie, exp_en[1], "mie_mtie");
		check_bit(mie_meie, exp_en[2], "mie_meie");
	endtask

	task automatic drive_idle();
		csr_valid <= 1'b0;
		csr_kind <= csr_pkg::upd_load;
		csr_wdata <= '0;
		trap_enter <= 1'b0;
		trap_ret <= 1'b0;
		trap_is_intr <= 1'b0;
		trap_cause <= '0;
		sw_irq <= 1'b0;
		tmr_irq <= 1'b0;
		ext_irq <= 1'b0;
		retire <= 1'b0;
		in_dbg_mode <= 1'b0;
	endtask

	function automatic csr_pkg::csr_addr_t pick_addr(logic [31:0] v);
		case (v[4:0])
			5'd0: return csr_pkg::addr_mstatus;
			5'd1: return csr_pkg::addr_misa;
			5'd2, 5'd17: return csr_pkg::addr_mie;
			5'd3, 5'd18: return csr_pkg::addr_mtvec;
			5'd4: return csr_pkg::addr_mscratch;
			5'd5: return csr_pkg::addr_mepc;
			5'd6: return csr_pkg::addr_mcause;
			5'd7: return csr_pkg::addr_mtval;
			5'd8, 5'd19: return csr_pkg::addr_mip;
			5'd9: return csr_pkg::addr_mcycle;
			5'd10: return csr_pkg::addr_mcycleh;
			5'd11: return csr_pkg::addr_minstret;
			5'd12: return csr_pkg::addr_minstreth;
			5'd13: return csr_pkg::addr_mvendorid;
			5'd14: return csr_pkg::addr_marchid;
			5'd15: return csr_pkg::addr_mimpid;
			5'd16: return csr_pkg::addr_mhartid;
			5'd20: return 12'h7B0; // Dropped dcsr
			default: return v[31:20]; // Mostly unknown
		endcase
	endfunction

	task automatic drive_random();
		logic [31:0] a;
		logic [31:0] b;
		draw_random(a);
		draw_random(b);
		csr_valid <= b[24]; // Independent of the address choice
		csr_kind <= csr_pkg::upd_kind_t'(b[26:25]);
		csr_addr <= pick_addr(a);
		draw_random(a);
		csr_wdata <= a;
		trap_enter <= (b[3:0] == 4'd0);
		trap_ret <= (b[7:4] == 4'd0);
		trap_is_intr <= b[8];
		sw_irq <= b[9];
		tmr_irq <= b[10];
		ext_irq <= b[11];
		retire <= b[12];
		in_dbg_mode <= (b[15:13] == 3'd0);
		trap_cause <= b[23:16];
		draw_random(a);
		trap_ret_addr <= a;
		draw_random(a);
		trap_value <= a;
	endtask

	// Load FFFF_FFFE into the low word and expect the carry two edges later
	task automatic carry_test(csr_pkg::csr_addr_t lo_a, csr_pkg::csr_addr_t hi_a, logic is_cycle);
		csr_pkg::csr_word_t hi_base;
		advance_edge();
		drive_idle();
		retire <= 1'b1;
		csr_valid <= 1'b1;
		csr_addr <= lo_a;
		csr_wdata <= 32'hFFFF_FFFE;
		check_outputs();
		advance_edge();
		hi_base = is_cycle ? exp_cycle[63:32] : exp_instret[63:32];
		drive_idle();
		retire <= 1'b1;
		csr_addr <= hi_a;
		check_outputs();
		advance_edge();
		check_outputs();
		advance_edge();
		check_outputs();
		check_word(csr_rdata, hi_base + 32'd1, "high word after carry");
	endtask

	initial
	begin
		resetn = 1'b0;
		csr_addr = csr_pkg::addr_mstatus;
		csr_kind = csr_pkg::upd_load;
		csr_wdata = '0;
		csr_valid = 1'b0;
		trap_enter = 1'b0;
		trap_is_intr = 1'b0;
		trap_cause = '0;
		trap_ret_addr = '0;
		trap_value = '0;
		trap_ret = 1'b0;
		sw_irq = 1'b0;
		tmr_irq = 1'b0;
		ext_irq = 1'b0;
		retire = 1'b0;
		in_dbg_mode = 1'b0;
		rng_state = 32'h223d_799a;
		cycle_count = 0;
		known_mepc = 1'b0;
		known_mtval = 1'b0;
		known_mscratch = 1'b0;
		reset_addrs = '{csr_pkg::addr_mstatus, csr_pkg::addr_mie, csr_pkg::addr_mip,
			csr_pkg::addr_mtvec, csr_pkg::addr_mcause, csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh,
			csr_pkg::addr_minstret, csr_pkg::addr_minstreth};
		load_addrs = '{csr_pkg::addr_mepc, csr_pkg::addr_mtval, csr_pkg::addr_mscratch};
		repeat (5)
			advance_edge();
		resetn <= 1'b1;
		wait_count = 0;
		while (resetn !== 1'b1)
		begin
			#1;
			wait_count = wait_count + 1;
			if (wait_count > 20)
			begin
				$display("Timeout: reset was never released");
				stop_run();
			end
		end
		foreach (reset_addrs[i])
		begin
			advance_edge();
			drive_idle();
			csr_addr <= reset_addrs[i];
			check_outputs();
		end
		foreach (load_addrs[i])
		begin
			advance_edge();
			drive_idle();
			draw_random(r);
			csr_valid <= 1'b1;
			csr_addr <= load_addrs[i];
			csr_wdata <= r;
			check_outputs();
		end
		repeat (random_cycles)
		begin
			advance_edge();
			drive_random();
			check_outputs();
		end
		carry_test(csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh, 1'b1);
		carry_test(csr_pkg::addr_minstret, csr_pkg::addr_minstreth, 1'b0);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* design/csr_counter64.sv */
// 64-bit counter as two CSR words; a write to one word does not stop the other from counting
`timescale 1ns/1ps

module csr_counter64
#(
	parameter csr_pkg::csr_addr_t lo_addr = csr_pkg::addr_mcycle,
	parameter csr_pkg::csr_addr_t hi_addr = csr_pkg::addr_mcycleh
)
(
	input logic clk,
	input logic resetn,

	input csr_pkg::csr_addr_t csr_addr,
	input csr_pkg::upd_kind_t csr_kind,
	input csr_pkg::csr_word_t csr_wdata,
	input logic csr_valid,

	input logic count_en,

	output csr_pkg::csr_word_t rdata
);

	csr_pkg::csr_word_t lo_q;
	csr_pkg::csr_word_t hi_q;
	logic wr_lo;
	logic wr_hi;
	logic carry; // Low word wraps at this edge

	assign wr_lo = csr_valid && (csr_addr == lo_addr);
	assign wr_hi = csr_valid && (csr_addr == hi_addr);
	assign carry = count_en && (&lo_q);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			lo_q <= '0;
			hi_q <= '0;
		end
		else
		begin
			if (wr_lo)
				lo_q <= csr_pkg::csr_update(lo_q, csr_kind, csr_wdata);
			else if (count_en)
				lo_q <= lo_q + 1'b1;
			if (wr_hi)
				hi_q <= csr_pkg::csr_update(hi_q, csr_kind, csr_wdata);
			else if (carry)
				hi_q <= hi_q + 1'b1;
		end
	end

	assign rdata = (csr_addr == lo_addr) ? lo_q :
		(csr_addr == hi_addr) ? hi_q : '0;

endmodule

/* design/csr_file.sv */
// M-mode CSR block top; reads are combinational, writes land at the next edge, no back-pressure
`timescale 1ns/1ps

module csr_file
(
	input logic clk,
	input logic resetn,

	// Atomic access port
	input csr_pkg::csr_addr_t csr_addr,
	input csr_pkg::upd_kind_t csr_kind,
	input csr_pkg::csr_word_t csr_wdata,
	input logic csr_valid,
	output csr_pkg::csr_word_t csr_rdata,

	// Trap entry and return
	input logic trap_enter,
	input logic trap_is_intr,
	input logic [csr_pkg::cause_w-1:0] trap_cause,
	input csr_pkg::csr_word_t trap_ret_addr,
	input csr_pkg::csr_word_t trap_value,
	output csr_pkg::csr_word_t trap_vec_addr,
	input logic trap_ret,
	output csr_pkg::csr_word_t mepc_ret_addr,

	input logic sw_irq,
	input logic tmr_irq,
	input logic ext_irq,
	input logic retire, // One instruction retired
	input logic in_dbg_mode, // Stops both counters

	output logic mstatus_mie,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie
);

	csr_pkg::csr_word_t trap_rdata;
	csr_pkg::csr_word_t irq_rdata;
	csr_pkg::csr_word_t cycle_rdata;
	csr_pkg::csr_word_t instret_rdata;
	csr_pkg::csr_word_t local_rdata; // mscratch and identity
	csr_pkg::csr_word_t mscratch_q;
	logic cycle_en;
	logic instret_en;

	csr_trap_regs trap_regs
	(
		.clk(clk),
		.resetn(resetn),
		.csr_addr(csr_addr),
		.csr_kind(csr_kind),
		.csr_wdata(csr_wdata),
		.csr_valid(csr_valid),
		.trap_enter(trap_enter),
		.trap_is_intr(trap_is_intr),
		.trap_cause(trap_cause),
		.trap_ret_addr(trap_ret_addr),
		.trap_value(trap_value),
		.trap_ret(trap_ret),
		.rdata(trap_rdata),
		.trap_vec_addr(trap_vec_addr),
		.mepc_ret_addr(mepc_ret_addr),
		.mstatus_mie(mstatus_mie)
	);

	csr_irq_regs irq_regs
	(
		.clk(clk),
		.resetn(resetn),
		.csr_addr(csr_addr),
		.csr_kind(csr_kind),
		.csr_wdata(csr_wdata),
		.csr_valid(csr_valid),
		.sw_irq(sw_irq),
		.tmr_irq(tmr_irq),
		.ext_irq(ext_irq),
		.rdata(irq_rdata),
		.mie_msie(mie_msie),
		.mie_mtie(mie_mtie),
		.mie_meie(mie_meie)
	);

	assign cycle_en = !in_dbg_mode;
	assign instret_en = retire && !in_dbg_mode;

	csr_counter64 #(.lo_addr(csr_pkg::addr_mcycle), .hi_addr(csr_pkg::addr_mcycleh)) cycle_counter
	(
		.clk(clk),
		.resetn(resetn),
		.csr_addr(csr_addr),
		.csr_kind(csr_kind),
		.csr_wdata(csr_wdata),
		.csr_valid(csr_valid),
		.count_en(cycle_en),
		.rdata(cycle_rdata)
	);

	csr_counter64
	#(
		.lo_addr(csr_pkg::addr_minstret),
		.hi_addr(csr_pkg::addr_minstreth)
	) retire_counter
	(
		.clk(clk),
		.resetn(resetn),
		.csr_addr(csr_addr),
		.csr_kind(csr_kind),
		.csr_wdata(csr_wdata),
		.csr_valid(csr_valid),
		.count_en(instret_en),
		.rdata(instret_rdata)
	);

	// Scratch word for the trap handler
	always_ff @(posedge clk)
	begin
		if (csr_valid && (csr_addr == csr_pkg::addr_mscratch))
			mscratch_q <= csr_pkg::csr_update(mscratch_q, csr_kind, csr_wdata);
	end

	always_comb
	begin
		case (csr_addr)
			csr_pkg::addr_mscratch: local_rdata = mscratch_q;
			csr_pkg::addr_misa: local_rdata = csr_pkg::misa_value;
			csr_pkg::addr_mvendorid: local_rdata = csr_pkg::mvendorid_value;
			csr_pkg::addr_marchid: local_rdata = csr_pkg::marchid_value;
			csr_pkg::addr_mimpid: local_rdata = csr_pkg::mimpid_value;
			csr_pkg::addr_mhartid: local_rdata = csr_pkg::mhartid_value;
			default: local_rdata = '0;
		endcase
	end

	// Unknown addresses fall through as zero
	assign csr_rdata = trap_rdata | irq_rdata | cycle_rdata | instret_rdata | local_rdata;

endmodule

/* design/csr_irq_regs.sv */
// mie enables and mip pending bits; mip is read-only and lags the request levels by one cycle
`timescale 1ns/1ps

module csr_irq_regs
(
	input logic clk,
	input logic resetn,

	input csr_pkg::csr_addr_t csr_addr,
	input csr_pkg::upd_kind_t csr_kind,
	input csr_pkg::csr_word_t csr_wdata,
	input logic csr_valid,

	input logic sw_irq,
	input logic tmr_irq,
	input logic ext_irq,

	output csr_pkg::csr_word_t rdata,
	output logic mie_msie,
	output logic mie_mtie,
	output logic mie_meie
);

	logic en_msi;
	logic en_mti;
	logic en_mei;
	logic pend_msi;
	logic pend_mti;
	logic pend_mei;

	csr_pkg::csr_word_t mie_word;
	csr_pkg::csr_word_t mip_word;
	csr_pkg::csr_word_t mie_new;
	logic wr_mie;

	always_comb
	begin
		mie_word = '0;
		mie_word[csr_pkg::bit_msi] = en_msi;
		mie_word[csr_pkg::bit_mti] = en_mti;
		mie_word[csr_pkg::bit_mei] = en_mei;
		mip_word = '0;
		mip_word[csr_pkg::bit_msi] = pend_msi;
		mip_word[csr_pkg::bit_mti] = pend_mti;
		mip_word[csr_pkg::bit_mei] = pend_mei;
	end

	assign wr_mie = csr_valid && (csr_addr == csr_pkg::addr_mie);
	assign mie_new = csr_pkg::csr_update(mie_word, csr_kind, csr_wdata);

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			en_msi <= 1'b0;
			en_mti <= 1'b0;
			en_mei <= 1'b0;
			pend_msi <= 1'b0;
			pend_mti <= 1'b0;
			pend_mei <= 1'b0;
		end
		else
		begin
			if (wr_mie)
			begin
				en_msi <= mie_new[csr_pkg::bit_msi];
				en_mti <= mie_new[csr_pkg::bit_mti];
				en_mei <= mie_new[csr_pkg::bit_mei];
			end
			pend_msi <= sw_irq; // Sampled every cycle
			pend_mti <= tmr_irq;
			pend_mei <= ext_irq;
		end
	end

	assign mie_msie = en_msi;
	assign mie_mtie = en_mti;
	assign mie_meie = en_mei;

	assign rdata = (csr_addr == csr_pkg::addr_mie) ? mie_word :
		(csr_addr == csr_pkg::addr_mip) ? mip_word : '0;

endmodule

/* design/csr_pkg.sv */
// Machine-mode CSR definitions for RV32 only; WARL fields are stored as written, not legalized
package csr_pkg;

	localparam int xlen = 32; // Register and data width

	typedef logic [11:0] csr_addr_t;
	typedef logic [xlen-1:0] csr_word_t;

	// Update kinds of the atomic access port; code 2'b11 leaves the register as it is
	typedef enum logic [1:0]
	{
		upd_load = 2'b00,
		upd_set = 2'b01,
		upd_clear = 2'b10
	} upd_kind_t;

	localparam csr_addr_t addr_mstatus = 12'h300;
	localparam csr_addr_t addr_misa = 12'h301;
	localparam csr_addr_t addr_mie = 12'h304;
	localparam csr_addr_t addr_mtvec = 12'h305;
	localparam csr_addr_t addr_mscratch = 12'h340;
	localparam csr_addr_t addr_mepc = 12'h341;
	localparam csr_addr_t addr_mcause = 12'h342;
	localparam csr_addr_t addr_mtval = 12'h343;
	localparam csr_addr_t addr_mip = 12'h344;
	localparam csr_addr_t addr_mcycle = 12'hB00;
	localparam csr_addr_t addr_minstret = 12'hB02;
	localparam csr_addr_t addr_mcycleh = 12'hB80;
	localparam csr_addr_t addr_minstreth = 12'hB82;
	localparam csr_addr_t addr_mvendorid = 12'hF11;
	localparam csr_addr_t addr_marchid = 12'hF12;
	localparam csr_addr_t addr_mimpid = 12'hF13;
	localparam csr_addr_t addr_mhartid = 12'hF14;

	localparam int bit_mie = 3; // mstatus fields
	localparam int bit_mpie = 7;
	localparam int bit_msi = 3; // Same positions in mie and mip
	localparam int bit_mti = 7;
	localparam int bit_mei = 11;

	localparam logic [1:0] mtvec_mode_vectored = 2'b01; // Interrupts jump to base + 4*cause
	localparam int cause_w = 8; // Width of the trap cause code

	localparam logic [29:0] rst_mtvec_base = 30'd0;
	localparam csr_word_t rst_mcause = {1'b0, 31'd16}; // Not an interrupt, code 16
	localparam csr_word_t misa_value = 32'h4000_1100; // MXL=1, RV32IM
	localparam csr_word_t mvendorid_value = 32'h0000_0000; // Non-commercial
	localparam csr_word_t marchid_value = 32'h0000_0000;
	localparam csr_word_t mimpid_value = 32'h312E_3030; // "1.00"
	localparam csr_word_t mhartid_value = 32'h0000_0000; // Single hart

	localparam csr_word_t mstatus_mpp_bits = 32'h0000_1800; // MPP reads as machine mode

	// New register word for one atomic access; clear ANDs with the mask as given
	function automatic csr_word_t csr_update(csr_word_t old_word, upd_kind_t kind,
		csr_word_t mask_value);
		csr_word_t new_word;
		case (kind)
			upd_load: new_word = mask_value;
			upd_set: new_word = old_word | mask_value;
			upd_clear: new_word = old_word & mask_value;
			default: new_word = old_word; // Reserved code, no change
		endcase
		return new_word;
	endfunction

endpackage

/* design/csr_trap_regs.sv */
// Trap CSRs; trap_enter wins over trap_ret and both win over an atomic write; mepc/mtval unreset
`timescale 1ns/1ps

module csr_trap_regs
(
	input logic clk,
	input logic resetn,

	input csr_pkg::csr_addr_t csr_addr,
	input csr_pkg::upd_kind_t csr_kind,
	input csr_pkg::csr_word_t csr_wdata,
	input logic csr_valid,

	input logic trap_enter,
	input logic trap_is_intr,
	input logic [csr_pkg::cause_w-1:0] trap_cause,
	input csr_pkg::csr_word_t trap_ret_addr,
	input csr_pkg::csr_word_t trap_value,
	input logic trap_ret,

	output csr_pkg::csr_word_t rdata,
	output csr_pkg::csr_word_t trap_vec_addr,
	output csr_pkg::csr_word_t mepc_ret_addr,
	output logic mstatus_mie
);

	logic status_mie; // mstatus.MIE
	logic status_mpie; // mstatus.MPIE
	csr_pkg::csr_word_t mtvec_q;
	csr_pkg::csr_word_t mepc_q;
	csr_pkg::csr_word_t mcause_q;
	csr_pkg::csr_word_t mtval_q;

	csr_pkg::csr_word_t mstatus_word; // Read view of mstatus
	csr_pkg::csr_word_t mstatus_new;
	csr_pkg::csr_word_t vec_base;
	csr_pkg::csr_word_t vec_offset;

	logic wr_mstatus;
	logic wr_mtvec;
	logic wr_mepc;
	logic wr_mcause;
	logic wr_mtval;

	assign wr_mstatus = csr_valid && (csr_addr == csr_pkg::addr_mstatus);
	assign wr_mtvec = csr_valid && (csr_addr == csr_pkg::addr_mtvec);
	assign wr_mepc = csr_valid && (csr_addr == csr_pkg::addr_mepc);
	assign wr_mcause = csr_valid && (csr_addr == csr_pkg::addr_mcause);
	assign wr_mtval = csr_valid && (csr_addr == csr_pkg::addr_mtval);

	always_comb
	begin
		mstatus_word = csr_pkg::mstatus_mpp_bits;
		mstatus_word[csr_pkg::bit_mie] = status_mie;
		mstatus_word[csr_pkg::bit_mpie] = status_mpie;
	end

	assign mstatus_new = csr_pkg::csr_update(mstatus_word, csr_kind, csr_wdata);
	assign mstatus_mie = status_mie;
	assign mepc_ret_addr = mepc_q;

	// Interrupt enable stack
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			status_mie <= 1'b0;
			status_mpie <= 1'b1;
		end
		else if (trap_enter)
		begin
			status_mie <= 1'b0; // Interrupts off in the handler
			status_mpie <= status_mie;
		end
		else if (trap_ret)
		begin
			status_mie <= status_mpie;
			status_mpie <= 1'b1;
		end
		else if (wr_mstatus)
		begin
			status_mie <= mstatus_new[csr_pkg::bit_mie];
			status_mpie <= mstatus_new[csr_pkg::bit_mpie];
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			mtvec_q <= {csr_pkg::rst_mtvec_base, 2'b00}; // Direct mode
			mcause_q <= csr_pkg::rst_mcause;
		end
		else
		begin
			if (wr_mtvec)
				mtvec_q <= csr_pkg::csr_update(mtvec_q, csr_kind, csr_wdata);
			if (trap_enter)
				mcause_q <= {trap_is_intr, {(csr_pkg::xlen-1-csr_pkg::cause_w){1'b0}}, trap_cause};
			else if (wr_mcause)
				mcause_q <= csr_pkg::csr_update(mcause_q, csr_kind, csr_wdata);
		end
	end

	// Trap address and value registers
	always_ff @(posedge clk)
	begin
		if (trap_enter)
		begin
			mepc_q <= trap_ret_addr;
			mtval_q <= trap_value;
		end
		else
		begin
			if (wr_mepc)
				mepc_q <= csr_pkg::csr_update(mepc_q, csr_kind, csr_wdata);
			if (wr_mtval)
				mtval_q <= csr_pkg::csr_update(mtval_q, csr_kind, csr_wdata);
		end
	end

	assign vec_base = {mtvec_q[csr_pkg::xlen-1:2], 2'b00};
	assign vec_offset = {{(csr_pkg::xlen-csr_pkg::cause_w-2){1'b0}}, trap_cause, 2'b00};
	// Only interrupts are vectored, exceptions always go to base
	assign trap_vec_addr = ((mtvec_q[1:0] == csr_pkg::mtvec_mode_vectored) && trap_is_intr) ?
		(vec_base + vec_offset) : vec_base;

	always_comb
	begin
		case (csr_addr)
			csr_pkg::addr_mstatus: rdata = mstatus_word;
			csr_pkg::addr_mtvec: rdata = mtvec_q;
			csr_pkg::addr_mepc: rdata = mepc_q;
			csr_pkg::addr_mcause: rdata = mcause_q;
			csr_pkg::addr_mtval: rdata = mtval_q;
			default: rdata = '0; // Not ours
		endcase
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the CSR block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f vlog.f --top-module csr_file_tb -Mdir "$OBJ"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vcsr_file_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Pass line not found in $LOG"
	exit 1
fi

/* vlog.f */
design/csr_pkg.sv
design/csr_trap_regs.sv
design/csr_irq_regs.sv
design/csr_counter64.sv
design/csr_file.sv
bench/csr_file_tb.sv
